/* Bender.yml */
package:
  name: swu

sources:
  - files:
      - verilog/swu_pkg.sv
      - verilog/swu_input_ctrl.sv
      - verilog/swu_window_gen.sv
      - verilog/swu_line_buffer.sv
      - verilog/swu_output_stage.sv
      - verilog/swu_top.sv
  - target: test
    files:
      - test/swu_assert.sv
      - test/tb_swu.sv

/* filelist.f */
verilog/swu_pkg.sv
verilog/swu_input_ctrl.sv
verilog/swu_window_gen.sv
verilog/swu_line_buffer.sv
verilog/swu_output_stage.sv
verilog/swu_top.sv
test/swu_assert.sv
test/tb_swu.sv

/* test/swu_assert.sv */
`timescale 1ns/1ps

module swu_assert (
   input logic           clk,
   input logic           resetn,
   input logic           s_valid_i,
   input logic           s_ready_o,
   input logic           frame_done,
   input swu_pkg::word_t m_data_o,
   input logic           m_valid_o,
   input logic           m_ready_i
);
   import swu_pkg::*;

   int   fail_count = 0;
   idx_t acc_count;

   // input words accepted on the stream port in the current frame
   always_ff @(posedge clk) begin
      if (!resetn) begin
         acc_count <= '0;
      end else if (frame_done) begin
         acc_count <= '0;
      end else if (s_valid_i && s_ready_o) begin
         acc_count <= acc_count + 1'b1;
      end
   end

   // stalled output holds its word
   assert property (@(posedge clk) disable iff (!resetn)
      m_valid_o && !m_ready_i |=> m_valid_o && $stable(m_data_o))
      else begin
         fail_count++;
         $error("output word changed or dropped while stalled");
      end

   // no input between the last word of a frame and the frame restart
   assert property (@(posedge clk) disable iff (!resetn)
      acc_count == idx_t'(FRAME_WORDS) |-> !s_ready_o)
      else begin
         fail_count++;
         $error("input accepted after a full frame was written");
      end

   assert property (@(posedge clk) !resetn |=> !m_valid_o)
      else begin
         fail_count++;
         $error("output valid high in the cycle after reset");
      end

endmodule

bind swu_top swu_assert u_assert (
   .clk        (clk),
   .resetn     (resetn),
   .s_valid_i  (s_valid_i),
   .s_ready_o  (s_ready_o),
   .frame_done (frame_done),
   .m_data_o   (m_data_o),
   .m_valid_o  (m_valid_o),
   .m_ready_i  (m_ready_i)
);

/* test/tb_swu.sv */
`timescale 1ns/1ps

module tb_swu;
   import swu_pkg::*;

   localparam int NUM_FRAMES     = 6;
   localparam int TIMEOUT_CYCLES = 8 * OUT_FRAME_WORDS * NUM_FRAMES + 100;

   logic  clk;
   logic  resetn;
   word_t s_data_i;
   logic  s_valid_i;
   logic  s_ready_o;
   word_t m_data_o;
   logic  m_valid_o;
   logic  m_ready_i;

   logic [31:0] lfsr;
   word_t       in_q[$];
   word_t       exp_q[$];
   int          in_ptr;
   int          exp_ptr;
   int          errors;
   int          cycles;
   string       test_name;

   swu_top u_dut (
      .clk       (clk),
      .resetn    (resetn),
      .s_data_i  (s_data_i),
      .s_valid_i (s_valid_i),
      .s_ready_o (s_ready_o),
      .m_data_o  (m_data_o),
      .m_valid_o (m_valid_o),
      .m_ready_i (m_ready_i)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   //////////////////////////////////////////////////
   // helpers
   //////////////////////////////////////////////////

   // fibonacci lfsr, taps 32 22 2 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      logic fb;
      fb = s[31] ^ s[21] ^ s[1] ^ s[0];
      return {s[30:0], fb};
   endfunction

   task draw_bits(input int n, output logic [31:0] val);
      int k;
      val = '0;
      for (k = 0; k < n; k++) begin
         lfsr = lfsr_next(lfsr);
         val  = {val[30:0], lfsr[0]};
      end
   endtask

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      if (expected !== actual) begin
         errors++;
         $display("Mismatch %s: expected %0h, actual %0h", name, expected, actual);
      end
   endtask

   // random input frames and the window words they should produce
   task build_frames(input int nframes);
      word_t       frame [FRAME_WORDS];
      logic [31:0] r;
      int          f, i, orow, ocol, kh, kw, g, idx;
      for (f = 0; f < nframes; f++) begin
         for (i = 0; i < FRAME_WORDS; i++) begin
            draw_bits(WORD_W, r);
            frame[i] = r[WORD_W-1:0];
            in_q.push_back(frame[i]);
         end
         for (orow = 0; orow < OFM_HEIGHT; orow++)
            for (ocol = 0; ocol < OFM_WIDTH; ocol++)
               for (kh = 0; kh < KERNEL_HEIGHT; kh++)
                  for (kw = 0; kw < KERNEL_WIDTH; kw++)
                     for (g = 0; g < EFF_CHANNELS; g++) begin
                        idx = ((orow * STRIDE + kh) * IFM_WIDTH + ocol * STRIDE + kw)
                              * EFF_CHANNELS + g;
                        exp_q.push_back(frame[idx]);
                     end
      end
   endtask

   // drive frames until every expected word of the phase has come out
   task run_phase(input string name, input int nframes, input bit rand_in, input bit rand_out);
      int          sent;
      int          target;
      logic [31:0] r;
      test_name = name;
      build_frames(nframes);
      sent   = 0;
      target = exp_q.size();
      while (sent < nframes * FRAME_WORDS || exp_ptr < target) begin
         @(negedge clk);
         if (rand_out) begin
            draw_bits(1, r);
            m_ready_i = r[0];
         end else begin
            m_ready_i = 1'b1;
         end
         if (sent < nframes * FRAME_WORDS) begin
            if (rand_in) begin
               draw_bits(1, r);
               s_valid_i = r[0];
            end else begin
               s_valid_i = 1'b1;
            end
            draw_bits(WORD_W, r);
            s_data_i = s_valid_i ? in_q[in_ptr] : r[WORD_W-1:0];
         end else begin
            s_valid_i = 1'b0;
         end
         @(posedge clk);
         if (s_valid_i && s_ready_o) begin
            sent++;
            in_ptr++;
         end
      end
      // idle with the output open, nothing more may appear
      @(negedge clk);
      s_valid_i = 1'b0;
      m_ready_i = 1'b1;
      repeat (20) @(negedge clk);
      check_value({name, "_count"}, target, exp_ptr);
   endtask

   task finish_run;
      $display("errors: %0d, assertion errors: %0d, output words: %0d",
               errors, u_dut.u_assert.fail_count, exp_ptr);
      if (errors == 0 && u_dut.u_assert.fail_count == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   endtask

   //////////////////////////////////////////////////
   // output scoreboard
   //////////////////////////////////////////////////
   always @(posedge clk) begin
      if (resetn && m_valid_o && m_ready_i) begin
         if (exp_ptr < exp_q.size()) begin
            check_value(test_name, exp_q[exp_ptr], m_data_o);
         end else begin
            errors++;
            $display("extra output word %0h after all expected words were seen", m_data_o);
         end
         exp_ptr <= exp_ptr + 1;
      end
   end

   initial begin
      cycles = 0;
      while (cycles < TIMEOUT_CYCLES) begin
         @(posedge clk);
         cycles++;
      end
      $display("timeout after %0d cycles, the window stream did not complete", cycles);
      errors++;
      finish_run();
   end

   //////////////////////////////////////////////////
   // test sequence
   //////////////////////////////////////////////////
   initial begin
      lfsr      = 32'h9c4;
      resetn    = 1'b0;
      s_valid_i = 1'b0;
      s_data_i  = '0;
      m_ready_i = 1'b0;
      in_ptr    = 0;
      exp_ptr   = 0;
      errors    = 0;
      test_name = "reset";
      repeat (4) @(posedge clk);
      @(negedge clk);
      resetn = 1'b1;
      @(negedge clk);
      check_value("reset_m_valid", 0, m_valid_o);
      check_value("reset_s_ready", 1, s_ready_o);

      run_phase("full_rate", 1, 1'b0, 1'b0);
      run_phase("back_pressure", 1, 1'b0, 1'b1);
      run_phase("input_gaps", 1, 1'b1, 1'b0);
      run_phase("back_to_back", 3, 1'b1, 1'b1);
      check_value("all_outputs", exp_q.size(), exp_ptr);
      finish_run();
   end

endmodule

/* verilog/swu_input_ctrl.sv */
`timescale 1ns/1ps

module swu_input_ctrl (
   input  logic              clk,
   input  logic              resetn,
   // input stream
   input  swu_pkg::word_t    s_data_i,
   input  logic              s_valid_i,
   output logic              s_ready_o,
   // from the window generator
   input  swu_pkg::idx_t     win_start_i,
   input  logic              frame_done_i,
   output swu_pkg::idx_t     wr_count_o,
   // buffer write port
   output logic              wr_en_o,
   output swu_pkg::buf_addr_t wr_addr_o,
   output swu_pkg::word_t    wr_data_o
);
   import swu_pkg::*;

   idx_t wr_count;
   idx_t fill;
   logic frame_open;
   logic space_ok;
   logic s_hs;

   //////////////////////////////////////////////////
   // space rule
   //////////////////////////////////////////////////

   // words written ahead of the current window start
   assign fill = wr_count - win_start_i;

   // a new word reuses the entry BUFFER_DEPTH words back,
   // which is behind the window start while fill is below the depth
   assign space_ok   = fill < idx_t'(BUFFER_DEPTH);
   assign frame_open = wr_count < idx_t'(FRAME_WORDS);

   assign s_ready_o = frame_open && space_ok;
   assign s_hs      = s_valid_i && s_ready_o;

   //////////////////////////////////////////////////
   // buffer write
   //////////////////////////////////////////////////
   assign wr_en_o   = s_hs;
   assign wr_addr_o = wr_count[BUF_ADDR_W-1:0];
   assign wr_data_o = s_data_i;

   // frame write count, held at FRAME_WORDS until the last window is issued
   always_ff @(posedge clk) begin
      if (!resetn) begin
         wr_count <= '0;
      end else if (frame_done_i) begin
         wr_count <= '0;
      end else if (s_hs) begin
         wr_count <= wr_count + 1'b1;
      end
   end

   assign wr_count_o = wr_count;

endmodule

/* verilog/swu_line_buffer.sv */
`timescale 1ns/1ps

module swu_line_buffer (
   input  logic               clk,
   // write port, driven by the input control
   input  logic               wr_en_i,
   input  swu_pkg::buf_addr_t wr_addr_i,
   input  swu_pkg::word_t     wr_data_i,
   // read port, data one cycle after the request
   input  logic               rd_en_i,
   input  swu_pkg::buf_addr_t rd_addr_i,
   output swu_pkg::word_t     rd_data_o
);
   import swu_pkg::*;

   // circular storage indexed by the low bits of the frame index
   word_t mem [BUFFER_DEPTH];
   word_t rd_data;

   always_ff @(posedge clk) begin
      if (wr_en_i) begin
         mem[wr_addr_i] <= wr_data_i;
      end
   end

   // registered read, held while no read is requested
   always_ff @(posedge clk) begin
      if (rd_en_i) begin
         rd_data <= mem[rd_addr_i];
      end
   end

   assign rd_data_o = rd_data;

endmodule

/* verilog/swu_output_stage.sv */
`timescale 1ns/1ps

module swu_output_stage (
   input  logic           clk,
   input  logic           resetn,
   // read returning from the buffer
   input  logic           rd_en_i,
   input  swu_pkg::word_t rd_data_i,
   output logic           issue_ready_o,
   // output stream
   output swu_pkg::word_t m_data_o,
   output logic           m_valid_o,
   input  logic           m_ready_i
);
   import swu_pkg::*;

   logic       rd_pending;
   logic       out_valid;
   logic       skid_valid;
   word_t      out_data;
   word_t      skid_data;
   logic       out_load;
   logic [1:0] occupancy;

   //////////////////////////////////////////////////
   // occupancy and issue credit
   //////////////////////////////////////////////////

   // read data shows up one cycle after the request
   always_ff @(posedge clk) begin
      if (!resetn) begin
         rd_pending <= 1'b0;
      end else begin
         rd_pending <= rd_en_i;
      end
   end

   // words in flight plus words held, never more than two
   assign occupancy = {1'b0, rd_pending} + {1'b0, out_valid} + {1'b0, skid_valid};
   assign issue_ready_o = occupancy < 2'd2;

   // output register is free or empties this cycle
   assign out_load = !out_valid || m_ready_i;

   //////////////////////////////////////////////////
   // output and skid registers
   //////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (!resetn) begin
         out_valid  <= 1'b0;
         skid_valid <= 1'b0;
      end else if (out_load) begin
         out_valid  <= skid_valid || rd_pending;
         skid_valid <= skid_valid && rd_pending;
      end else if (rd_pending) begin
         // output stalled, park the returning word
         skid_valid <= 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (out_load) begin
         // skid word is older, it goes out first
         if (skid_valid) begin
            out_data <= skid_data;
         end else if (rd_pending) begin
            out_data <= rd_data_i;
         end
      end
      if (rd_pending && (!out_load || skid_valid)) begin
         skid_data <= rd_data_i;
      end
   end

   assign m_valid_o = out_valid;
   assign m_data_o  = out_data;

endmodule

/* verilog/swu_pkg.sv */
package swu_pkg;

   //////////////////////////////////////////////////
   // input feature map and kernel geometry
   //////////////////////////////////////////////////
   localparam int SIMD          = 4;
   localparam int IP_PRECISION  = 4;
   localparam int IFM_CHANNELS  = 8;
   localparam int EFF_CHANNELS  = IFM_CHANNELS / SIMD;
   localparam int IFM_WIDTH     = 6;
   localparam int IFM_HEIGHT    = 6;
   localparam int KERNEL_WIDTH  = 3;
   localparam int KERNEL_HEIGHT = 3;
   localparam int STRIDE        = 1;
   localparam int OFM_WIDTH     = (IFM_WIDTH - KERNEL_WIDTH) / STRIDE + 1;
   localparam int OFM_HEIGHT    = (IFM_HEIGHT - KERNEL_HEIGHT) / STRIDE + 1;

   //////////////////////////////////////////////////
   // derived sizes
   //////////////////////////////////////////////////
   localparam int WORD_W          = SIMD * IP_PRECISION;
   localparam int ROW_WORDS       = IFM_WIDTH * EFF_CHANNELS;
   localparam int FRAME_WORDS     = ROW_WORDS * IFM_HEIGHT;
   localparam int WINDOW_WORDS    = KERNEL_WIDTH * KERNEL_HEIGHT * EFF_CHANNELS;
   localparam int OUT_FRAME_WORDS = OFM_WIDTH * OFM_HEIGHT * WINDOW_WORDS;
   // words between the first and the last element of one window, inclusive
   localparam int WINDOW_SPAN     = (KERNEL_HEIGHT - 1) * ROW_WORDS + KERNEL_WIDTH * EFF_CHANNELS;
   localparam int BUFFER_DEPTH    = 1 << $clog2(WINDOW_SPAN);
   localparam int BUF_ADDR_W      = $clog2(BUFFER_DEPTH);
   localparam int IDX_W           = $clog2(FRAME_WORDS) + 1;

   // window base steps, one output column and one output row
   localparam int COL_STEP = STRIDE * EFF_CHANNELS;
   localparam int ROW_STEP = STRIDE * ROW_WORDS;

   // window walk counter widths
   localparam int CH_CNT_W = (EFF_CHANNELS > 1) ? $clog2(EFF_CHANNELS) : 1;
   localparam int KW_CNT_W = (KERNEL_WIDTH > 1) ? $clog2(KERNEL_WIDTH) : 1;
   localparam int KH_CNT_W = (KERNEL_HEIGHT > 1) ? $clog2(KERNEL_HEIGHT) : 1;
   localparam int OC_CNT_W = (OFM_WIDTH > 1) ? $clog2(OFM_WIDTH) : 1;
   localparam int OR_CNT_W = (OFM_HEIGHT > 1) ? $clog2(OFM_HEIGHT) : 1;

   //////////////////////////////////////////////////
   // types
   //////////////////////////////////////////////////
   typedef logic [WORD_W-1:0]     word_t;
   typedef logic [IDX_W-1:0]      idx_t;
   // a buffer address is the low bits of an in-frame index
   typedef logic [BUF_ADDR_W-1:0] buf_addr_t;

endpackage

/* verilog/swu_top.sv */
`timescale 1ns/1ps

module swu_top (
   input  logic           clk,
   input  logic           resetn,
   // input feature map stream
   input  swu_pkg::word_t s_data_i,
   input  logic           s_valid_i,
   output logic           s_ready_o,
   // window stream
   output swu_pkg::word_t m_data_o,
   output logic           m_valid_o,
   input  logic           m_ready_i
);
   import swu_pkg::*;

   // buffer write side
   logic      wr_en;
   buf_addr_t wr_addr;
   word_t     wr_data;
   idx_t      wr_count;

   // window walk
   idx_t      win_start;
   logic      frame_done;
   logic      rd_en;
   buf_addr_t rd_addr;
   word_t     rd_data;
   logic      issue_ready;

   swu_input_ctrl u_input_ctrl (
      .clk          (clk),
      .resetn       (resetn),
      .s_data_i     (s_data_i),
      .s_valid_i    (s_valid_i),
      .s_ready_o    (s_ready_o),
      .win_start_i  (win_start),
      .frame_done_i (frame_done),
      .wr_count_o   (wr_count),
      .wr_en_o      (wr_en),
      .wr_addr_o    (wr_addr),
      .wr_data_o    (wr_data)
   );

   swu_window_gen u_window_gen (
      .clk           (clk),
      .resetn        (resetn),
      .wr_count_i    (wr_count),
      .issue_ready_i (issue_ready),
      .rd_en_o       (rd_en),
      .rd_addr_o     (rd_addr),
      .win_start_o   (win_start),
      .frame_done_o  (frame_done)
   );

   swu_line_buffer u_line_buffer (
      .clk       (clk),
      .wr_en_i   (wr_en),
      .wr_addr_i (wr_addr),
      .wr_data_i (wr_data),
      .rd_en_i   (rd_en),
      .rd_addr_i (rd_addr),
      .rd_data_o (rd_data)
   );

   swu_output_stage u_output_stage (
      .clk           (clk),
      .resetn        (resetn),
      .rd_en_i       (rd_en),
      .rd_data_i     (rd_data),
      .issue_ready_o (issue_ready),
      .m_data_o      (m_data_o),
      .m_valid_o     (m_valid_o),
      .m_ready_i     (m_ready_i)
   );

endmodule

/* verilog/swu_window_gen.sv */
`timescale 1ns/1ps

module swu_window_gen (
   input  logic               clk,
   input  logic               resetn,
   input  swu_pkg::idx_t      wr_count_i,
   input  logic               issue_ready_i,
   // buffer read request
   output logic               rd_en_o,
   output swu_pkg::buf_addr_t rd_addr_o,
   // flow control back to the input side
   output swu_pkg::idx_t      win_start_o,
   output logic               frame_done_o
);
   import swu_pkg::*;

   // walk counters, innermost first
   logic [CH_CNT_W-1:0] ch_cnt;
   logic [KW_CNT_W-1:0] kw_cnt;
   logic [KH_CNT_W-1:0] kh_cnt;
   logic [OC_CNT_W-1:0] oc_cnt;
   logic [OR_CNT_W-1:0] or_cnt;

   // first word of the current window and of the current output row
   idx_t win_base;
   idx_t row_base;

   idx_t elem_off;
   idx_t rd_idx;
   logic avail;
   logic ch_wrap;
   logic kw_wrap;
   logic kh_wrap;
   logic oc_wrap;
   logic or_wrap;
   logic win_end;

   //////////////////////////////////////////////////
   // element index and issue
   //////////////////////////////////////////////////

   // offset inside the window in kernel row, kernel column, channel group order
   assign elem_off = idx_t'(kh_cnt) * idx_t'(ROW_WORDS)
                   + idx_t'(kw_cnt) * idx_t'(EFF_CHANNELS)
                   + idx_t'(ch_cnt);
   assign rd_idx   = win_base + elem_off;

   // the word must already be in the buffer
   assign avail = rd_idx < wr_count_i;

   assign rd_en_o   = avail && issue_ready_i;
   assign rd_addr_o = rd_idx[BUF_ADDR_W-1:0];

   assign ch_wrap = ch_cnt == CH_CNT_W'(EFF_CHANNELS - 1);
   assign kw_wrap = kw_cnt == KW_CNT_W'(KERNEL_WIDTH - 1);
   assign kh_wrap = kh_cnt == KH_CNT_W'(KERNEL_HEIGHT - 1);
   assign oc_wrap = oc_cnt == OC_CNT_W'(OFM_WIDTH - 1);
   assign or_wrap = or_cnt == OR_CNT_W'(OFM_HEIGHT - 1);

   // last element of a window leaves the issue stage this cycle
   assign win_end = rd_en_o && ch_wrap && kw_wrap && kh_wrap;

   assign frame_done_o = win_end && oc_wrap && or_wrap;
   assign win_start_o  = win_base;

   //////////////////////////////////////////////////
   // counters
   //////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (!resetn) begin
         ch_cnt <= '0;
         kw_cnt <= '0;
         kh_cnt <= '0;
      end else if (rd_en_o) begin
         ch_cnt <= ch_wrap ? '0 : ch_cnt + 1'b1;
         if (ch_wrap) begin
            kw_cnt <= kw_wrap ? '0 : kw_cnt + 1'b1;
            if (kw_wrap) begin
               kh_cnt <= kh_wrap ? '0 : kh_cnt + 1'b1;
            end
         end
      end
   end

   // output pixel position and window base
   always_ff @(posedge clk) begin
      if (!resetn) begin
         oc_cnt   <= '0;
         or_cnt   <= '0;
         win_base <= '0;
         row_base <= '0;
      end else if (win_end) begin
         if (!oc_wrap) begin
            oc_cnt   <= oc_cnt + 1'b1;
            win_base <= win_base + idx_t'(COL_STEP);
         end else if (!or_wrap) begin
            oc_cnt   <= '0;
            or_cnt   <= or_cnt + 1'b1;
            row_base <= row_base + idx_t'(ROW_STEP);
            win_base <= row_base + idx_t'(ROW_STEP);
         end else begin
            // frame complete, start over at the first window
            oc_cnt   <= '0;
            or_cnt   <= '0;
            row_base <= '0;
            win_base <= '0;
         end
      end
   end

endmodule
